/* verilog/lc3b_defines.svh */
`ifndef LC3B_DEFINES_SVH
`define LC3B_DEFINES_SVH

// datapath width
`define LC3B_WORD_W 16

// register file geometry
`define LC3B_NUM_REGS 8
`define LC3B_REG_W 3

// return address register for jsr, jsrr and trap
`define LC3B_LINK_REG 7

`endif

/* verilog/lc3b_pkg.sv */
`include "lc3b_defines.svh"

package lc3b_pkg;

	typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
	typedef logic [`LC3B_REG_W-1:0] lc3b_reg;

	// raw immediate fields, before any extension
	typedef logic [7:0] lc3b_offset8;
	typedef logic [8:0] lc3b_offset9;
	typedef logic [10:0] lc3b_offset11;

	// instr[15:12], subset handled here
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_not  = 4'b1001,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass
	} lc3b_aluop;

	// 2'b11 never selected
	typedef enum logic [1:0] {
		fwd_reg   = 2'b00,
		fwd_wb    = 2'b01,
		fwd_exmem = 2'b10
	} lc3b_fwd_sel;

endpackage

/* verilog/ex_ctrl_if.sv */
`timescale 1ns/1ps

interface ex_ctrl_if (
	input logic clk
);
	import lc3b_pkg::*;

	lc3b_aluop aluop;
	logic sr2mux_sel;
	logic alumux_sel;
	logic bradd2mux_sel;
	logic link_sel;
	logic wr_en;
	logic redirect_en;
	lc3b_reg dest;
	lc3b_reg sr1_idx;
	lc3b_reg sr2_idx;
	lc3b_word sr1;
	lc3b_word sr2;
	lc3b_word imm_word;
	lc3b_offset8 offset8;
	lc3b_offset9 offset9;
	lc3b_offset11 offset11;
	lc3b_word pc;
	logic valid;

	modport decode (
		output aluop, sr2mux_sel, alumux_sel, bradd2mux_sel, link_sel, wr_en,
		redirect_en, dest, sr1_idx, sr2_idx, sr1, sr2, imm_word, offset8,
		offset9, offset11, pc, valid
	);

	modport execute (
		input aluop, sr2mux_sel, alumux_sel, bradd2mux_sel, link_sel, wr_en,
		redirect_en, dest, sr1, sr2, imm_word, offset8, offset9, offset11, pc,
		valid
	);

	modport fwd (
		input clk, valid, sr1_idx, sr2_idx
	);

endinterface

/* verilog/regfile.sv */
`timescale 1ns/1ps
`include "lc3b_defines.svh"

module regfile (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               wr,
	input  lc3b_pkg::lc3b_reg  wr_idx,
	input  lc3b_pkg::lc3b_word wr_data,
	input  lc3b_pkg::lc3b_reg  rd1_idx,
	input  lc3b_pkg::lc3b_reg  rd2_idx,
	output lc3b_pkg::lc3b_word rd1,
	output lc3b_pkg::lc3b_word rd2
);
	import lc3b_pkg::*;

	lc3b_word regs [`LC3B_NUM_REGS];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `LC3B_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// a read of the register being written sees the new value
	assign rd1 = (wr && wr_idx == rd1_idx) ? wr_data : regs[rd1_idx];
	assign rd2 = (wr && wr_idx == rd2_idx) ? wr_data : regs[rd2_idx];

endmodule

/* verilog/decode_stage.sv */
`timescale 1ns/1ps
`include "lc3b_defines.svh"

module decode_stage (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               instr_valid,
	input  lc3b_pkg::lc3b_word instr,
	input  lc3b_pkg::lc3b_word pc,
	output lc3b_pkg::lc3b_reg  rd1_idx,
	output lc3b_pkg::lc3b_reg  rd2_idx,
	input  lc3b_pkg::lc3b_word rd1,
	input  lc3b_pkg::lc3b_word rd2,
	ex_ctrl_if.decode          ctrl
);
	import lc3b_pkg::*;

	lc3b_opcode opcode;
	lc3b_reg dr;
	lc3b_word imm5_sext;
	logic known;
	logic issue;
	lc3b_aluop aluop;
	logic sr2mux_sel;
	logic alumux_sel;
	logic bradd2mux_sel;
	logic link_sel;
	logic wr_en;
	logic redirect_en;
	lc3b_reg dest;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// field split
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign opcode = lc3b_opcode'(instr[15:12]);
	assign dr = instr[11:9];
	// baser of jsrr sits where sr1 does
	assign rd1_idx = instr[8:6];
	assign rd2_idx = instr[2:0];
	assign imm5_sext = {{(`LC3B_WORD_W-5){instr[4]}}, instr[4:0]};

	always_comb begin
		known = 1'b1;
		aluop = alu_pass;
		sr2mux_sel = 1'b0;
		alumux_sel = 1'b0;
		bradd2mux_sel = 1'b0;
		link_sel = 1'b0;
		wr_en = 1'b0;
		redirect_en = 1'b0;
		dest = dr;
		case (opcode)
			op_add: begin
				aluop = alu_add;
				sr2mux_sel = instr[5];
				wr_en = 1'b1;
			end
			op_and: begin
				aluop = alu_and;
				sr2mux_sel = instr[5];
				wr_en = 1'b1;
			end
			op_not: begin
				aluop = alu_not;
				wr_en = 1'b1;
			end
			op_lea: begin
				wr_en = 1'b1;
			end
			// nzp field doubles as dr
			op_br: begin
				redirect_en = |dr;
			end
			op_jsr: begin
				bradd2mux_sel = ~instr[11];
				link_sel = 1'b1;
				wr_en = 1'b1;
				redirect_en = 1'b1;
				dest = lc3b_reg'(`LC3B_LINK_REG);
			end
			op_trap: begin
				alumux_sel = 1'b1;
				link_sel = 1'b1;
				wr_en = 1'b1;
				redirect_en = 1'b1;
				dest = lc3b_reg'(`LC3B_LINK_REG);
			end
			default: known = 1'b0;
		endcase
	end

	assign issue = instr_valid && known;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// id/ex register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ctrl.valid <= 1'b0;
			ctrl.wr_en <= 1'b0;
			ctrl.redirect_en <= 1'b0;
		end else begin
			ctrl.valid <= issue;
			ctrl.wr_en <= issue && wr_en;
			ctrl.redirect_en <= issue && redirect_en;
		end
	end

	always_ff @(posedge clk) begin
		ctrl.aluop <= aluop;
		ctrl.sr2mux_sel <= sr2mux_sel;
		ctrl.alumux_sel <= alumux_sel;
		ctrl.bradd2mux_sel <= bradd2mux_sel;
		ctrl.link_sel <= link_sel;
		ctrl.dest <= dest;
		ctrl.sr1_idx <= rd1_idx;
		ctrl.sr2_idx <= rd2_idx;
		ctrl.sr1 <= rd1;
		ctrl.sr2 <= rd2;
		ctrl.imm_word <= imm5_sext;
		ctrl.offset8 <= instr[7:0];
		ctrl.offset9 <= instr[8:0];
		ctrl.offset11 <= instr[10:0];
		ctrl.pc <= pc;
	end

	// illegal opcodes are dropped before execute, raw lc3b encodings
	assert property (@(posedge clk) disable iff (!rst_n)
		instr_valid && !(instr[15:12] inside {4'b0000, 4'b0001, 4'b0100, 4'b0101,
			4'b1001, 4'b1110, 4'b1111}) |=> !ctrl.valid);

endmodule

/* verilog/forward_unit.sv */
`timescale 1ns/1ps

module forward_unit (
	ex_ctrl_if.fwd                ctrl,
	input  lc3b_pkg::lc3b_reg     exmem_dest,
	input  lc3b_pkg::lc3b_reg     wb_dest,
	input  logic                  exmem_wr,
	input  logic                  wb_wr,
	output lc3b_pkg::lc3b_fwd_sel sr1_forward_sel,
	output lc3b_pkg::lc3b_fwd_sel sr2_forward_sel
);
	import lc3b_pkg::*;

	// youngest producer wins
	function automatic lc3b_fwd_sel pick_src(
		input logic    valid,
		input lc3b_reg idx,
		input logic    ex_wr,
		input lc3b_reg ex_dest,
		input logic    mw_wr,
		input lc3b_reg mw_dest
	);
		lc3b_fwd_sel sel;
		sel = fwd_reg;
		if (valid && ex_wr && ex_dest == idx) begin
			sel = fwd_exmem;
		end else if (valid && mw_wr && mw_dest == idx) begin
			sel = fwd_wb;
		end
		return sel;
	endfunction

	assign sr1_forward_sel = pick_src(ctrl.valid, ctrl.sr1_idx, exmem_wr, exmem_dest,
		wb_wr, wb_dest);
	assign sr2_forward_sel = pick_src(ctrl.valid, ctrl.sr2_idx, exmem_wr, exmem_dest,
		wb_wr, wb_dest);

	// an ex/mem producer becomes the mem/wb producer on the next edge
	assert property (@(posedge ctrl.clk)
		exmem_wr |=> wb_wr && wb_dest == $past(exmem_dest));

endmodule

/* verilog/execute_stage.sv */
`timescale 1ns/1ps
`include "lc3b_defines.svh"

module execute_stage (
	input  logic                  clk,
	ex_ctrl_if.execute            ctrl,
	input  lc3b_pkg::lc3b_fwd_sel sr1_forward_sel,
	input  lc3b_pkg::lc3b_fwd_sel sr2_forward_sel,
	input  lc3b_pkg::lc3b_word    alu_ex_mem_out,
	input  lc3b_pkg::lc3b_word    write_data,
	output lc3b_pkg::lc3b_word    result,
	output lc3b_pkg::lc3b_word    br_add_out,
	output lc3b_pkg::lc3b_word    bradd2mux_out
);
	import lc3b_pkg::*;

	lc3b_word sr1_fwd;
	lc3b_word sr2_fwd;
	lc3b_word adj9_out;
	lc3b_word adj11_out;
	lc3b_word br_add2_out;
	lc3b_word sr2mux_out;
	lc3b_word alu_a;
	lc3b_word alu_out;
	lc3b_word trapvect;

	function automatic lc3b_word fwd_mux(
		input lc3b_fwd_sel sel,
		input lc3b_word    reg_val,
		input lc3b_word    wb_val,
		input lc3b_word    exmem_val
	);
		lc3b_word val;
		case (sel)
			fwd_exmem: val = exmem_val;
			fwd_wb: val = wb_val;
			default: val = reg_val;
		endcase
		return val;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// operand forwarding
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign sr1_fwd = fwd_mux(sr1_forward_sel, ctrl.sr1, write_data, alu_ex_mem_out);
	assign sr2_fwd = fwd_mux(sr2_forward_sel, ctrl.sr2, write_data, alu_ex_mem_out);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pc-relative adders
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// word offsets, sext then x2
	assign adj9_out = {{(`LC3B_WORD_W-10){ctrl.offset9[8]}}, ctrl.offset9, 1'b0};
	assign adj11_out = {{(`LC3B_WORD_W-12){ctrl.offset11[10]}}, ctrl.offset11, 1'b0};

	assign br_add_out = ctrl.pc + adj9_out;
	assign br_add2_out = ctrl.pc + adj11_out;

	// jsrr jumps to baser
	assign bradd2mux_out = ctrl.bradd2mux_sel ? sr1_fwd : br_add2_out;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// alu and result select
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign sr2mux_out = ctrl.sr2mux_sel ? ctrl.imm_word : sr2_fwd;

	// lea rides the pass op with the adder in place of sr1
	assign alu_a = (ctrl.aluop == alu_pass) ? br_add_out : sr1_fwd;

	always_comb begin
		case (ctrl.aluop)
			alu_add: alu_out = alu_a + sr2mux_out;
			alu_and: alu_out = alu_a & sr2mux_out;
			alu_not: alu_out = ~alu_a;
			default: alu_out = alu_a;
		endcase
	end

	assign trapvect = {{(`LC3B_WORD_W-9){1'b0}}, ctrl.offset8, 1'b0};
	assign result = ctrl.alumux_sel ? trapvect : alu_out;

	// ex/mem carries the value computed here unless it is a link write
	assert property (@(posedge clk)
		ctrl.valid && ctrl.wr_en && !ctrl.link_sel |=> alu_ex_mem_out == $past(result));

endmodule

/* verilog/writeback_stage.sv */
`timescale 1ns/1ps

module writeback_stage (
	input  logic               clk,
	input  logic               rst_n,
	ex_ctrl_if.execute         ctrl,
	input  lc3b_pkg::lc3b_word result,
	input  lc3b_pkg::lc3b_word br_add_out,
	input  lc3b_pkg::lc3b_word bradd2mux_out,
	output lc3b_pkg::lc3b_word alu_ex_mem_out,
	output lc3b_pkg::lc3b_reg  exmem_dest,
	output logic               exmem_wr,
	output lc3b_pkg::lc3b_word write_data,
	output lc3b_pkg::lc3b_reg  wb_dest,
	output logic               wb_wr,
	output logic               redirect,
	output lc3b_pkg::lc3b_word redirect_target
);
	import lc3b_pkg::*;

	lc3b_word ex_data;
	lc3b_word ex_target;

	// link writes the return address
	assign ex_data = ctrl.link_sel ? ctrl.pc : result;

	always_comb begin
		if (ctrl.alumux_sel) begin
			// trap vector
			ex_target = result;
		end else if (ctrl.link_sel) begin
			ex_target = bradd2mux_out;
		end else begin
			ex_target = br_add_out;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// ex/mem
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			exmem_wr <= 1'b0;
			redirect <= 1'b0;
		end else begin
			exmem_wr <= ctrl.valid && ctrl.wr_en;
			redirect <= ctrl.valid && ctrl.redirect_en;
		end
	end

	always_ff @(posedge clk) begin
		alu_ex_mem_out <= ex_data;
		exmem_dest <= ctrl.dest;
		redirect_target <= ex_target;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// mem/wb, nothing to do in mem
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_wr <= 1'b0;
		end else begin
			wb_wr <= exmem_wr;
		end
	end

	always_ff @(posedge clk) begin
		write_data <= alu_ex_mem_out;
		wb_dest <= exmem_dest;
	end

	assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(wb_wr));

endmodule

/* verilog/lc3b_ex_core.sv */
`timescale 1ns/1ps

module lc3b_ex_core (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               instr_valid,
	input  lc3b_pkg::lc3b_word instr,
	input  lc3b_pkg::lc3b_word pc,
	output logic               wb_valid,
	output lc3b_pkg::lc3b_reg  wb_dest,
	output lc3b_pkg::lc3b_word wb_data,
	output logic               redirect,
	output lc3b_pkg::lc3b_word redirect_target
);
	import lc3b_pkg::*;

	lc3b_reg rd1_idx;
	lc3b_reg rd2_idx;
	lc3b_word rd1;
	lc3b_word rd2;
	lc3b_fwd_sel sr1_forward_sel;
	lc3b_fwd_sel sr2_forward_sel;
	lc3b_word result;
	lc3b_word br_add_out;
	lc3b_word bradd2mux_out;
	lc3b_word alu_ex_mem_out;
	lc3b_reg exmem_dest;
	logic exmem_wr;

	ex_ctrl_if u_ex_ctrl (
		.clk(clk)
	);

	regfile u_regfile (
		.clk(clk),
		.rst_n(rst_n),
		.wr(wb_valid),
		.wr_idx(wb_dest),
		.wr_data(wb_data),
		.rd1_idx(rd1_idx),
		.rd2_idx(rd2_idx),
		.rd1(rd1),
		.rd2(rd2)
	);

	decode_stage u_decode_stage (
		.clk(clk),
		.rst_n(rst_n),
		.instr_valid(instr_valid),
		.instr(instr),
		.pc(pc),
		.rd1_idx(rd1_idx),
		.rd2_idx(rd2_idx),
		.rd1(rd1),
		.rd2(rd2),
		.ctrl(u_ex_ctrl.decode)
	);

	forward_unit u_forward_unit (
		.ctrl(u_ex_ctrl.fwd),
		.exmem_dest(exmem_dest),
		.wb_dest(wb_dest),
		.exmem_wr(exmem_wr),
		.wb_wr(wb_valid),
		.sr1_forward_sel(sr1_forward_sel),
		.sr2_forward_sel(sr2_forward_sel)
	);

	execute_stage u_execute_stage (
		.clk(clk),
		.ctrl(u_ex_ctrl.execute),
		.sr1_forward_sel(sr1_forward_sel),
		.sr2_forward_sel(sr2_forward_sel),
		.alu_ex_mem_out(alu_ex_mem_out),
		.write_data(wb_data),
		.result(result),
		.br_add_out(br_add_out),
		.bradd2mux_out(bradd2mux_out)
	);

	writeback_stage u_writeback_stage (
		.clk(clk),
		.rst_n(rst_n),
		.ctrl(u_ex_ctrl.execute),
		.result(result),
		.br_add_out(br_add_out),
		.bradd2mux_out(bradd2mux_out),
		.alu_ex_mem_out(alu_ex_mem_out),
		.exmem_dest(exmem_dest),
		.exmem_wr(exmem_wr),
		.write_data(wb_data),
		.wb_dest(wb_dest),
		.wb_wr(wb_valid),
		.redirect(redirect),
		.redirect_target(redirect_target)
	);

endmodule

/* verif/tb_lc3b_ex_core.sv */
`timescale 1ns/1ps

module tb_lc3b_ex_core;

	localparam logic [3:0] opc_br = 4'b0000;
	localparam logic [3:0] opc_add = 4'b0001;
	localparam logic [3:0] opc_ldb = 4'b0010;
	localparam logic [3:0] opc_jsr = 4'b0100;
	localparam logic [3:0] opc_and = 4'b0101;
	localparam logic [3:0] opc_not = 4'b1001;
	localparam logic [3:0] opc_lea = 4'b1110;
	localparam logic [3:0] opc_trap = 4'b1111;
	localparam int drain_limit = 200;

	logic clk;
	logic rst_n;
	logic instr_valid;
	logic [15:0] instr;
	logic [15:0] pc;
	logic wb_valid;
	logic [2:0] wb_dest;
	logic [15:0] wb_data;
	logic redirect;
	logic [15:0] redirect_target;

	// shadow state and expected outputs, in issue order
	logic [15:0] shadow [8];
	logic [2:0] exp_dest [$];
	logic [15:0] exp_data [$];
	logic [15:0] exp_target [$];

	int cmp_errs;
	int run_errs;
	int test_num;
	int test_start_errs;
	int tests_passed;
	int tests_failed;
	integer seed;
	logic [15:0] next_pc;

	lc3b_ex_core u_lc3b_ex_core (
		.clk(clk),
		.rst_n(rst_n),
		.instr_valid(instr_valid),
		.instr(instr),
		.pc(pc),
		.wb_valid(wb_valid),
		.wb_dest(wb_dest),
		.wb_data(wb_data),
		.redirect(redirect),
		.redirect_target(redirect_target)
	);

	always #10 clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic void ref_exec(input logic [15:0] ins, input logic [15:0] pcv);
		logic [2:0] dr;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] off9;
		logic [15:0] off11;
		logic [15:0] val;
		logic [15:0] tgt;
		logic wr;
		logic rd;
		dr = ins[11:9];
		a = shadow[ins[8:6]];
		b = ins[5] ? {{11{ins[4]}}, ins[4:0]} : shadow[ins[2:0]];
		off9 = {{6{ins[8]}}, ins[8:0], 1'b0};
		off11 = {{4{ins[10]}}, ins[10:0], 1'b0};
		val = 16'h0000;
		tgt = 16'h0000;
		wr = 1'b0;
		rd = 1'b0;
		case (ins[15:12])
			opc_add: begin
				wr = 1'b1;
				val = a + b;
			end
			opc_and: begin
				wr = 1'b1;
				val = a & b;
			end
			opc_not: begin
				wr = 1'b1;
				val = ~a;
			end
			opc_lea: begin
				wr = 1'b1;
				val = pcv + off9;
			end
			opc_br: begin
				rd = |ins[11:9];
				tgt = pcv + off9;
			end
			// jsr when bit 11 is set, jsrr otherwise
			opc_jsr: begin
				wr = 1'b1;
				rd = 1'b1;
				dr = 3'd7;
				val = pcv;
				tgt = ins[11] ? pcv + off11 : a;
			end
			opc_trap: begin
				wr = 1'b1;
				rd = 1'b1;
				dr = 3'd7;
				val = pcv;
				tgt = {7'b0000000, ins[7:0], 1'b0};
			end
			default: begin
			end
		endcase
		if (wr) begin
			shadow[dr] = val;
			exp_dest.push_back(dr);
			exp_data.push_back(val);
		end
		if (rd) begin
			exp_target.push_back(tgt);
		end
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// comparison, sampled on the falling edge
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic check_write();
		logic [2:0] d;
		logic [15:0] v;
		if (exp_dest.size() == 0) begin
			$display("unexpected register write at %0t: R%0d = %h", $time, wb_dest, wb_data);
			cmp_errs++;
		end else begin
			d = exp_dest.pop_front();
			v = exp_data.pop_front();
			if (wb_dest !== d) begin
				$display("Fail at time %0t: wb_dest expected %0d got %0d", $time, d, wb_dest);
				cmp_errs++;
			end
			if (wb_data !== v) begin
				$display("Fail at time %0t: wb_data expected %h got %h", $time, v, wb_data);
				cmp_errs++;
			end
		end
	endtask

	task automatic check_redirect();
		logic [15:0] t;
		if (exp_target.size() == 0) begin
			$display("unexpected redirect at %0t to %h", $time, redirect_target);
			cmp_errs++;
		end else begin
			t = exp_target.pop_front();
			if (redirect_target !== t) begin
				$display("Fail at time %0t: redirect_target expected %h got %h",
					$time, t, redirect_target);
				cmp_errs++;
			end
		end
	endtask

	always @(negedge clk) begin
		if (rst_n) begin
			if (wb_valid) begin
				check_write();
			end
			if (redirect) begin
				check_redirect();
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic send(input logic [15:0] ins);
		@(posedge clk);
		#1;
		instr_valid = 1'b1;
		instr = ins;
		pc = next_pc;
		ref_exec(ins, next_pc);
		next_pc = next_pc + 16'd2;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
			instr_valid = 1'b0;
		end
	endtask

	task automatic drain();
		int cycles;
		cycles = 0;
		while ((exp_dest.size() != 0 || exp_target.size() != 0) && cycles < drain_limit) begin
			@(posedge clk);
			cycles++;
		end
		if (exp_dest.size() != 0 || exp_target.size() != 0) begin
			$display("timeout: %0d writes and %0d redirects never came out",
				exp_dest.size(), exp_target.size());
			run_errs++;
			exp_dest.delete();
			exp_data.delete();
			exp_target.delete();
		end
	endtask

	task automatic begin_test();
		test_num++;
		test_start_errs = cmp_errs + run_errs;
	endtask

	task automatic end_test(input string name);
		int errs;
		idle(1);
		drain();
		errs = cmp_errs + run_errs - test_start_errs;
		if (errs == 0) begin
			tests_passed++;
			$display("test %0d %s: pass", test_num, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", test_num, name, errs);
		end
	endtask

	function automatic logic [15:0] random_instr();
		logic [31:0] r;
		logic [15:0] ins;
		r = $random(seed);
		case (r[31:29])
			3'd1: ins = {opc_and, r[11:0]};
			3'd2: ins = {opc_not, r[11:6], 6'h3f};
			3'd3: ins = {opc_lea, r[11:0]};
			3'd4: ins = {opc_br, r[11:0]};
			3'd5: ins = r[11] ? {opc_jsr, r[11:0]} : {opc_jsr, 3'b000, r[8:6], 6'd0};
			3'd6: ins = {opc_trap, 4'd0, r[7:0]};
			default: ins = {opc_add, r[11:0]};
		endcase
		return ins;
	endfunction

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = 16'h0000;
		pc = 16'h0000;
		seed = 27273;
		cmp_errs = 0;
		run_errs = 0;
		test_num = 0;
		tests_passed = 0;
		tests_failed = 0;
		next_pc = 16'h3002;
		for (int i = 0; i < 8; i++) begin
			shadow[i] = 16'h0000;
		end
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;

		begin_test();
		idle(20);
		end_test("idle after reset");

		begin_test();
		send({opc_add, 3'd1, 3'd0, 1'b1, 5'd9});
		idle(4);
		send({opc_add, 3'd2, 3'd0, 1'b1, 5'h1c});
		idle(4);
		send({opc_add, 3'd3, 3'd1, 3'b000, 3'd2});
		idle(4);
		send({opc_and, 3'd4, 3'd2, 3'b000, 3'd1});
		idle(4);
		send({opc_and, 3'd5, 3'd2, 1'b1, 5'h0f});
		idle(4);
		send({opc_not, 3'd6, 3'd1, 6'h3f});
		idle(4);
		// ldb is not kept, no write and no redirect
		send({opc_ldb, 3'd1, 3'd1, 6'd0});
		end_test("alu register and immediate forms");

		// gap d-1 puts the consumer d edges behind its producer
		begin_test();
		for (int d = 1; d <= 3; d++) begin
			send({opc_add, 3'd1, 3'd1, 1'b1, 5'd3});
			idle(d - 1);
			send({opc_add, 3'd2, 3'd1, 3'b000, 3'd1});
			idle(d - 1);
			send({opc_and, 3'd3, 3'd2, 3'b000, 3'd1});
			idle(d - 1);
			send({opc_not, 3'd1, 3'd3, 6'h3f});
			idle(4);
		end
		for (int i = 0; i < 6; i++) begin
			send({opc_add, 3'd4, 3'd4, 1'b1, 5'd7});
		end
		end_test("dependent chains");

		begin_test();
		send({opc_lea, 3'd5, 9'h012});
		send({opc_lea, 3'd6, 9'h1f0});
		send({opc_br, 3'b111, 9'h020});
		send({opc_br, 3'b010, 9'h1fe});
		send({opc_br, 3'b000, 9'h040});
		send({opc_add, 3'd1, 3'd5, 1'b1, 5'd1});
		end_test("lea and br");

		begin_test();
		send({opc_jsr, 1'b1, 11'h123});
		send({opc_add, 3'd2, 3'd7, 1'b1, 5'd0});
		send({opc_jsr, 3'b000, 3'd2, 6'd0});
		send({opc_trap, 4'd0, 8'h25});
		send({opc_jsr, 3'b000, 3'd7, 6'd0});
		end_test("jsr jsrr and trap");

		begin_test();
		for (int i = 0; i < 300; i++) begin
			send(random_instr());
		end
		end_test("random back to back");

		// anything late still gets counted
		idle(5);
		$display("%0d tests passed, %0d tests failed, %0d errors",
			tests_passed, tests_failed, cmp_errs + run_errs);
		if (cmp_errs + run_errs == 0 && tests_failed == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* project.f */
+incdir+verilog
verilog/lc3b_pkg.sv
verilog/ex_ctrl_if.sv
verilog/regfile.sv
verilog/decode_stage.sv
verilog/forward_unit.sv
verilog/execute_stage.sv
verilog/writeback_stage.sv
verilog/lc3b_ex_core.sv
verif/tb_lc3b_ex_core.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_lc3b_ex_core
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
